/* wbi_bus_pkg.sv */
package wbi_bus_pkg;

  // ----------------------------
  // Bus widths
  // ----------------------------

  // Data and address follow the 32-bit Wishbone data bus
  localparam int WBI_DATA_W = 32;
  localparam int WBI_ADDR_W = 32;

  // One select bit per data byte
  localparam int WBI_SEL_W  = WBI_DATA_W / 8;

  // Wide enough to name every slave
  localparam int WBI_TID_W  = 2;

  // ----------------------------
  // Port counts
  // ----------------------------

  // m0 external host, m1 instruction port, m2 data port
  localparam int WBI_NUM_MST = 3;

  // s0 flash and SPI, s1 SDRAM, s2 global registers, s3 UART
  localparam int WBI_NUM_SLV = 4;

  // Request as it travels from master to slave
  typedef struct packed {
    logic [WBI_DATA_W-1:0] dat;
    logic [WBI_ADDR_W-1:0] adr;
    logic [WBI_SEL_W-1:0]  sel;
    logic                  we;
    logic                  cyc;
    logic                  stb;
    logic [WBI_TID_W-1:0]  tid;   // target slave
  } wbi_req_t;

  // Response from slave, read data plus ack
  typedef struct packed {
    logic [WBI_DATA_W-1:0] dat;
    logic                  ack;
  } wbi_rsp_t;

endpackage

/* wbi_map_pkg.sv */
package wbi_map_pkg;

  // ----------------------------
  // Address slices
  // ----------------------------

  // Region nibble sits in bits 31..28
  localparam int MAP_REGION_HI = wbi_bus_pkg::WBI_ADDR_W - 1;
  localparam int MAP_REGION_LO = MAP_REGION_HI - 3;

  // Page is the upper half-word, bits 31..16
  localparam int MAP_PAGE_LO   = MAP_REGION_HI - 15;

  // Byte offset bits inside one data word
  localparam int MAP_WORD_LSB  = 2;

  // ----------------------------
  // Memory map
  // ----------------------------

  // Regions 0 and 1 hold flash and SPI registers and need no constant
  localparam logic [3:0]  MAP_SDRAM_REGION = 4'h2;
  localparam logic [15:0] MAP_GLBL_PAGE    = 16'h3000;
  localparam logic [15:0] MAP_UART_PAGE    = 16'h3001;

  // Target ids, equal to the slave port index
  localparam logic [wbi_bus_pkg::WBI_TID_W-1:0] TID_FLASH = 2'd0;
  localparam logic [wbi_bus_pkg::WBI_TID_W-1:0] TID_SDRAM = 2'd1;
  localparam logic [wbi_bus_pkg::WBI_TID_W-1:0] TID_GLBL  = 2'd2;
  localparam logic [wbi_bus_pkg::WBI_TID_W-1:0] TID_UART  = 2'd3;

  // Global registers and UART decode only the low byte
  localparam int SLV_REG_ADDR_W = 8;

endpackage

/* wbi_req_if.sv */
`timescale 1ns/10ps

interface wbi_req_if;

  import wbi_bus_pkg::*;

  // Request side, one entry per master
  logic [WBI_NUM_MST-1:0][WBI_ADDR_W-1:0] adr;
  logic [WBI_NUM_MST-1:0][WBI_DATA_W-1:0] dat;
  logic [WBI_NUM_MST-1:0][WBI_SEL_W-1:0]  sel;
  logic [WBI_NUM_MST-1:0]                 we;
  logic [WBI_NUM_MST-1:0]                 cyc;
  logic [WBI_NUM_MST-1:0]                 stb;

  // Return side, driven by the staging stage
  logic [WBI_NUM_MST-1:0]                 ack;
  logic [WBI_NUM_MST-1:0][WBI_DATA_W-1:0] rdat;

  // Top level master ports
  modport src (
    output adr, dat, sel, we, cyc, stb,
    input  ack, rdat
  );

  // Arbiter only needs to see what is still pending
  modport arb (
    input stb, ack
  );

  // Decoder looks at addresses only
  modport dec (
    input adr
  );

  // Staging crossbar
  modport xbar (
    input  adr, dat, sel, we, cyc, stb,
    output ack, rdat
  );

endinterface

/* wbi_rr_arbiter.sv */
`timescale 1ns/10ps

module wbi_rr_arbiter (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  wbi_req_if.arb                            req_if,
  output logic [wbi_bus_pkg::WBI_TID_W-1:0] gnt_o
);

  import wbi_bus_pkg::*;

  // One pending bit per master
  logic [WBI_NUM_MST-1:0] req;

  // Current owner and its successor
  logic [WBI_TID_W-1:0]   gnt_q;
  logic [WBI_TID_W-1:0]   gnt_nxt;

  // ----------------------------
  // Pending requests
  // ----------------------------

  // A strobe counts until its ack comes back
  // so the owner lets go in its ack cycle
  assign req = req_if.stb & ~req_if.ack;

  // ----------------------------
  // Round-robin pick
  // ----------------------------

  always_comb begin : rr_pick
    int idx;
    gnt_nxt = gnt_q;
    idx     = 0;
    // Owner keeps the bus while it is still pending
    if (!req[gnt_q]) begin
      // Walk backwards so the nearest master after the owner wins
      for (int k = WBI_NUM_MST; k >= 1; k--) begin
        idx = (int'(gnt_q) + k) % WBI_NUM_MST;
        if (req[idx]) begin
          gnt_nxt = WBI_TID_W'(idx);
        end
      end
    end
  end

  // Grant register, m0 owns the bus out of reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gnt_q <= '0;
    end else begin
      gnt_q <= gnt_nxt;
    end
  end

  assign gnt_o = gnt_q;

endmodule

/* wbi_target_decode.sv */
`timescale 1ns/10ps

module wbi_target_decode (
  wbi_req_if.dec req_if,
  output logic [wbi_bus_pkg::WBI_NUM_MST-1:0][wbi_bus_pkg::WBI_TID_W-1:0] tid_o
);

  import wbi_bus_pkg::*;
  import wbi_map_pkg::*;

  // Address fields per master
  logic [WBI_NUM_MST-1:0][MAP_REGION_HI-MAP_REGION_LO:0] region;
  logic [WBI_NUM_MST-1:0][MAP_REGION_HI-MAP_PAGE_LO:0]   page;

  // ----------------------------
  // Memory map compare
  // ----------------------------

  always_comb begin
    for (int m = 0; m < WBI_NUM_MST; m++) begin
      region[m] = req_if.adr[m][MAP_REGION_HI:MAP_REGION_LO];
      page[m]   = req_if.adr[m][MAP_REGION_HI:MAP_PAGE_LO];

      // SDRAM owns a whole region
      if (region[m] == MAP_SDRAM_REGION) begin
        tid_o[m] = TID_SDRAM;
      end else if (page[m] == MAP_GLBL_PAGE) begin
        tid_o[m] = TID_GLBL;
      end else if (page[m] == MAP_UART_PAGE) begin
        tid_o[m] = TID_UART;
      end else begin
        // Regions 0 and 1 land here, so does anything unmapped
        tid_o[m] = TID_FLASH;
      end
    end
  end

endmodule

/* wbi_stage_xbar.sv */
`timescale 1ns/10ps

module wbi_stage_xbar (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  wbi_req_if.xbar               req_if,
  input  logic [wbi_bus_pkg::WBI_TID_W-1:0]                               gnt_i,
  input  logic [wbi_bus_pkg::WBI_NUM_MST-1:0][wbi_bus_pkg::WBI_TID_W-1:0] tid_i,
  output wbi_bus_pkg::wbi_req_t slv_req_o [wbi_bus_pkg::WBI_NUM_SLV],
  input  wbi_bus_pkg::wbi_rsp_t slv_rsp_i [wbi_bus_pkg::WBI_NUM_SLV]
);

  import wbi_bus_pkg::*;
  import wbi_map_pkg::*;

  // Granted master, address already word aligned
  wbi_req_t mst_req;

  // Staged payload and the request the slaves actually see
  wbi_req_t stg_q;
  wbi_req_t stg_req;

  // Staged control
  logic                 stg_cyc_q;
  logic                 stg_stb_q;
  logic [WBI_TID_W-1:0] stg_tid_q;

  // Response of the addressed slave
  wbi_rsp_t slv_rsp;

  // Registered return path to the masters
  logic                  mst_ack_q;
  logic [WBI_DATA_W-1:0] mst_dat_q;

  // Load a new request into the stage
  logic take;

  // Addressed slave acks the staged strobe
  logic done;

  // ----------------------------
  // Master side mux
  // ----------------------------

  always_comb begin
    mst_req.dat = req_if.dat[gnt_i];
    // Drop the byte offset
    mst_req.adr = {req_if.adr[gnt_i][WBI_ADDR_W-1:MAP_WORD_LSB], {MAP_WORD_LSB{1'b0}}};
    mst_req.sel = req_if.sel[gnt_i];
    mst_req.we  = req_if.we[gnt_i];
    mst_req.cyc = req_if.cyc[gnt_i];
    mst_req.stb = req_if.stb[gnt_i];
    mst_req.tid = tid_i[gnt_i];
  end

  // Stage empty and no ack on its way back
  // The ack cycle still shows the old strobe, so that one is skipped
  assign take = mst_req.cyc & mst_req.stb & ~stg_stb_q & ~mst_ack_q;

  assign slv_rsp = slv_rsp_i[stg_tid_q];
  assign done    = stg_stb_q & slv_rsp.ack;

  // ----------------------------
  // Staging registers
  // ----------------------------

  // Control part, cleared by reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      stg_cyc_q <= 1'b0;
      stg_stb_q <= 1'b0;
      stg_tid_q <= '0;
      mst_ack_q <= 1'b0;
    end else begin
      // Ack to the master is a single pulse
      mst_ack_q <= 1'b0;
      if (take) begin
        stg_cyc_q <= 1'b1;
        stg_stb_q <= 1'b1;
        stg_tid_q <= mst_req.tid;
      end else if (done) begin
        // Strobe drops together with the master ack
        stg_cyc_q <= 1'b0;
        stg_stb_q <= 1'b0;
        mst_ack_q <= 1'b1;
      end
    end
  end

  // Payload part, held steady until the slave acks
  always_ff @(posedge clk_i) begin
    if (take) begin
      stg_q <= mst_req;
    end
    if (done) begin
      mst_dat_q <= slv_rsp.dat;
    end
  end

  // Staged request with live control bits
  always_comb begin
    stg_req     = stg_q;
    stg_req.cyc = stg_cyc_q;
    stg_req.stb = stg_stb_q;
    stg_req.tid = stg_tid_q;
  end

  // ----------------------------
  // Slave and master routing
  // ----------------------------

  // Only the addressed slave gets the request, the rest see zeros
  always_comb begin
    for (int s = 0; s < WBI_NUM_SLV; s++) begin
      if (stg_tid_q == WBI_TID_W'(s)) begin
        slv_req_o[s] = stg_req;
      end else begin
        slv_req_o[s] = '0;
      end
    end
  end

  // Grant still points at the owner during its ack cycle
  always_comb begin
    for (int m = 0; m < WBI_NUM_MST; m++) begin
      if (mst_ack_q && (gnt_i == WBI_TID_W'(m))) begin
        req_if.ack[m]  = 1'b1;
        req_if.rdat[m] = mst_dat_q;
      end else begin
        req_if.ack[m]  = 1'b0;
        req_if.rdat[m] = '0;
      end
    end
  end

endmodule

/* wb_interconnect.sv */
`timescale 1ns/10ps

module wb_interconnect (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,

  // m0 external host
  input  logic [wbi_bus_pkg::WBI_DATA_W-1:0]       m0_wbd_dat_i,
  input  logic [wbi_bus_pkg::WBI_ADDR_W-1:0]       m0_wbd_adr_i,
  input  logic [wbi_bus_pkg::WBI_SEL_W-1:0]        m0_wbd_sel_i,
  input  logic                                     m0_wbd_we_i,
  input  logic                                     m0_wbd_cyc_i,
  input  logic                                     m0_wbd_stb_i,
  output logic [wbi_bus_pkg::WBI_DATA_W-1:0]       m0_wbd_dat_o,
  output logic                                     m0_wbd_ack_o,

  // m1 instruction port
  input  logic [wbi_bus_pkg::WBI_DATA_W-1:0]       m1_wbd_dat_i,
  input  logic [wbi_bus_pkg::WBI_ADDR_W-1:0]       m1_wbd_adr_i,
  input  logic [wbi_bus_pkg::WBI_SEL_W-1:0]        m1_wbd_sel_i,
  input  logic                                     m1_wbd_we_i,
  input  logic                                     m1_wbd_cyc_i,
  input  logic                                     m1_wbd_stb_i,
  output logic [wbi_bus_pkg::WBI_DATA_W-1:0]       m1_wbd_dat_o,
  output logic                                     m1_wbd_ack_o,

  // m2 data port
  input  logic [wbi_bus_pkg::WBI_DATA_W-1:0]       m2_wbd_dat_i,
  input  logic [wbi_bus_pkg::WBI_ADDR_W-1:0]       m2_wbd_adr_i,
  input  logic [wbi_bus_pkg::WBI_SEL_W-1:0]        m2_wbd_sel_i,
  input  logic                                     m2_wbd_we_i,
  input  logic                                     m2_wbd_cyc_i,
  input  logic                                     m2_wbd_stb_i,
  output logic [wbi_bus_pkg::WBI_DATA_W-1:0]       m2_wbd_dat_o,
  output logic                                     m2_wbd_ack_o,

  // s0 flash and SPI registers
  input  logic [wbi_bus_pkg::WBI_DATA_W-1:0]       s0_wbd_dat_i,
  input  logic                                     s0_wbd_ack_i,
  output logic [wbi_bus_pkg::WBI_DATA_W-1:0]       s0_wbd_dat_o,
  output logic [wbi_bus_pkg::WBI_ADDR_W-1:0]       s0_wbd_adr_o,
  output logic [wbi_bus_pkg::WBI_SEL_W-1:0]        s0_wbd_sel_o,
  output logic                                     s0_wbd_we_o,
  output logic                                     s0_wbd_cyc_o,
  output logic                                     s0_wbd_stb_o,

  // s1 SDRAM
  input  logic [wbi_bus_pkg::WBI_DATA_W-1:0]       s1_wbd_dat_i,
  input  logic                                     s1_wbd_ack_i,
  output logic [wbi_bus_pkg::WBI_DATA_W-1:0]       s1_wbd_dat_o,
  output logic [wbi_bus_pkg::WBI_ADDR_W-1:0]       s1_wbd_adr_o,
  output logic [wbi_bus_pkg::WBI_SEL_W-1:0]        s1_wbd_sel_o,
  output logic                                     s1_wbd_we_o,
  output logic                                     s1_wbd_cyc_o,
  output logic                                     s1_wbd_stb_o,

  // s2 global registers
  input  logic [wbi_bus_pkg::WBI_DATA_W-1:0]       s2_wbd_dat_i,
  input  logic                                     s2_wbd_ack_i,
  output logic [wbi_bus_pkg::WBI_DATA_W-1:0]       s2_wbd_dat_o,
  output logic [wbi_map_pkg::SLV_REG_ADDR_W-1:0]   s2_wbd_adr_o,
  output logic [wbi_bus_pkg::WBI_SEL_W-1:0]        s2_wbd_sel_o,
  output logic                                     s2_wbd_we_o,
  output logic                                     s2_wbd_cyc_o,
  output logic                                     s2_wbd_stb_o,

  // s3 UART
  input  logic [wbi_bus_pkg::WBI_DATA_W-1:0]       s3_wbd_dat_i,
  input  logic                                     s3_wbd_ack_i,
  output logic [wbi_bus_pkg::WBI_DATA_W-1:0]       s3_wbd_dat_o,
  output logic [wbi_map_pkg::SLV_REG_ADDR_W-1:0]   s3_wbd_adr_o,
  output logic [wbi_bus_pkg::WBI_SEL_W-1:0]        s3_wbd_sel_o,
  output logic                                     s3_wbd_we_o,
  output logic                                     s3_wbd_cyc_o,
  output logic                                     s3_wbd_stb_o
);

  import wbi_bus_pkg::*;
  import wbi_map_pkg::*;

  wbi_req_if u_req_if ();

  logic [WBI_TID_W-1:0]                  gnt;
  logic [WBI_NUM_MST-1:0][WBI_TID_W-1:0] tid;

  // Slave side of the staging stage, indexed by target id
  wbi_req_t slv_req [WBI_NUM_SLV];
  wbi_rsp_t slv_rsp [WBI_NUM_SLV];

  // ----------------------------
  // Master ports
  // ----------------------------

  // Highest master first so index matches master number
  assign u_req_if.dat = {m2_wbd_dat_i, m1_wbd_dat_i, m0_wbd_dat_i};
  assign u_req_if.adr = {m2_wbd_adr_i, m1_wbd_adr_i, m0_wbd_adr_i};
  assign u_req_if.sel = {m2_wbd_sel_i, m1_wbd_sel_i, m0_wbd_sel_i};
  assign u_req_if.we  = {m2_wbd_we_i, m1_wbd_we_i, m0_wbd_we_i};
  assign u_req_if.cyc = {m2_wbd_cyc_i, m1_wbd_cyc_i, m0_wbd_cyc_i};
  assign u_req_if.stb = {m2_wbd_stb_i, m1_wbd_stb_i, m0_wbd_stb_i};

  assign m0_wbd_dat_o = u_req_if.rdat[0];
  assign m0_wbd_ack_o = u_req_if.ack[0];
  assign m1_wbd_dat_o = u_req_if.rdat[1];
  assign m1_wbd_ack_o = u_req_if.ack[1];
  assign m2_wbd_dat_o = u_req_if.rdat[2];
  assign m2_wbd_ack_o = u_req_if.ack[2];

  // ----------------------------
  // Arbitration and decode
  // ----------------------------

  wbi_rr_arbiter u_arb (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_if  (u_req_if),
    .gnt_o   (gnt)
  );

  wbi_target_decode u_dec (
    .req_if (u_req_if),
    .tid_o  (tid)
  );

  // Mux, staging flops and slave routing
  wbi_stage_xbar u_xbar (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_if    (u_req_if),
    .gnt_i     (gnt),
    .tid_i     (tid),
    .slv_req_o (slv_req),
    .slv_rsp_i (slv_rsp)
  );

  // ----------------------------
  // Slave ports
  // ----------------------------

  assign slv_rsp[TID_FLASH] = '{dat: s0_wbd_dat_i, ack: s0_wbd_ack_i};
  assign slv_rsp[TID_SDRAM] = '{dat: s1_wbd_dat_i, ack: s1_wbd_ack_i};
  assign slv_rsp[TID_GLBL]  = '{dat: s2_wbd_dat_i, ack: s2_wbd_ack_i};
  assign slv_rsp[TID_UART]  = '{dat: s3_wbd_dat_i, ack: s3_wbd_ack_i};

  // Flash takes the full address
  assign s0_wbd_dat_o = slv_req[TID_FLASH].dat;
  assign s0_wbd_adr_o = slv_req[TID_FLASH].adr;
  assign s0_wbd_sel_o = slv_req[TID_FLASH].sel;
  assign s0_wbd_we_o  = slv_req[TID_FLASH].we;
  assign s0_wbd_cyc_o = slv_req[TID_FLASH].cyc;
  assign s0_wbd_stb_o = slv_req[TID_FLASH].stb;

  // SDRAM sees an offset inside its region, region nibble cleared
  assign s1_wbd_dat_o = slv_req[TID_SDRAM].dat;
  assign s1_wbd_adr_o = {{(WBI_ADDR_W-MAP_REGION_LO){1'b0}},
                         slv_req[TID_SDRAM].adr[MAP_REGION_LO-1:0]};
  assign s1_wbd_sel_o = slv_req[TID_SDRAM].sel;
  assign s1_wbd_we_o  = slv_req[TID_SDRAM].we;
  assign s1_wbd_cyc_o = slv_req[TID_SDRAM].cyc;
  assign s1_wbd_stb_o = slv_req[TID_SDRAM].stb;

  // Register blocks only decode the low byte
  assign s2_wbd_dat_o = slv_req[TID_GLBL].dat;
  assign s2_wbd_adr_o = slv_req[TID_GLBL].adr[SLV_REG_ADDR_W-1:0];
  assign s2_wbd_sel_o = slv_req[TID_GLBL].sel;
  assign s2_wbd_we_o  = slv_req[TID_GLBL].we;
  assign s2_wbd_cyc_o = slv_req[TID_GLBL].cyc;
  assign s2_wbd_stb_o = slv_req[TID_GLBL].stb;

  assign s3_wbd_dat_o = slv_req[TID_UART].dat;
  assign s3_wbd_adr_o = slv_req[TID_UART].adr[SLV_REG_ADDR_W-1:0];
  assign s3_wbd_sel_o = slv_req[TID_UART].sel;
  assign s3_wbd_we_o  = slv_req[TID_UART].we;
  assign s3_wbd_cyc_o = slv_req[TID_UART].cyc;
  assign s3_wbd_stb_o = slv_req[TID_UART].stb;

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset held low over the first two rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* tb_wb_interconnect.sv */
`timescale 1ns/10ps

module tb_wb_interconnect;

  localparam int NUM_TXN     = 15;
  localparam int TXN_WORDS   = 6;
  localparam int CYCLE_LIMIT = 40 * NUM_TXN;

  logic clk;
  logic rst_n;

  // Transaction table with six words per line of the data file
  logic [31:0] txn_mem [NUM_TXN*TXN_WORDS];

  // Master side
  logic [31:0] m_dat  [3];
  logic [31:0] m_adr  [3];
  logic [3:0]  m_sel  [3];
  logic        m_we   [3];
  logic        m_cyc  [3];
  logic        m_stb  [3];
  logic [31:0] m_rdat [3];
  logic        m_ack  [3];

  // Slave side with s2 and s3 addresses widened to 32 bits
  logic [31:0] s_wdat [4];
  logic [31:0] s_adr  [4];
  logic [3:0]  s_sel  [4];
  logic        s_we   [4];
  logic        s_cyc  [4];
  logic        s_stb  [4];
  logic [7:0]  s2_adr;
  logic [7:0]  s3_adr;
  logic [31:0] s_rdat [4] = '{default: '0};
  logic        s_ack  [4] = '{default: 1'b0};

  // Slave model state
  logic        busy      [4];
  logic [1:0]  wait_cnt  [4];
  logic [31:0] snap_adr  [4];
  logic [31:0] snap_wdat [4];
  logic [3:0]  snap_sel  [4];
  logic        snap_we   [4];
  logic [15:0] lfsr = 16'd31768;
  logic [31:0] slv_mem [logic [33:0]];

  // Last request any slave took
  logic [1:0]  last_slv;
  logic [31:0] last_adr;
  logic [31:0] last_wdat;
  logic [3:0]  last_sel;
  logic        last_we;
  logic        last_cyc;

  // Expected memory contents, fairness marks, watchdog
  logic [31:0] exp_mem [logic [33:0]];
  logic [2:0]  served [3];
  int          cycle_cnt = 0;

  assign s_adr[2] = {24'd0, s2_adr};
  assign s_adr[3] = {24'd0, s3_adr};

  tb_clock_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  wb_interconnect uut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .m0_wbd_dat_i (m_dat[0]),
    .m0_wbd_adr_i (m_adr[0]),
    .m0_wbd_sel_i (m_sel[0]),
    .m0_wbd_we_i  (m_we[0]),
    .m0_wbd_cyc_i (m_cyc[0]),
    .m0_wbd_stb_i (m_stb[0]),
    .m0_wbd_dat_o (m_rdat[0]),
    .m0_wbd_ack_o (m_ack[0]),
    .m1_wbd_dat_i (m_dat[1]),
    .m1_wbd_adr_i (m_adr[1]),
    .m1_wbd_sel_i (m_sel[1]),
    .m1_wbd_we_i  (m_we[1]),
    .m1_wbd_cyc_i (m_cyc[1]),
    .m1_wbd_stb_i (m_stb[1]),
    .m1_wbd_dat_o (m_rdat[1]),
    .m1_wbd_ack_o (m_ack[1]),
    .m2_wbd_dat_i (m_dat[2]),
    .m2_wbd_adr_i (m_adr[2]),
    .m2_wbd_sel_i (m_sel[2]),
    .m2_wbd_we_i  (m_we[2]),
    .m2_wbd_cyc_i (m_cyc[2]),
    .m2_wbd_stb_i (m_stb[2]),
    .m2_wbd_dat_o (m_rdat[2]),
    .m2_wbd_ack_o (m_ack[2]),
    .s0_wbd_dat_i (s_rdat[0]),
    .s0_wbd_ack_i (s_ack[0]),
    .s0_wbd_dat_o (s_wdat[0]),
    .s0_wbd_adr_o (s_adr[0]),
    .s0_wbd_sel_o (s_sel[0]),
    .s0_wbd_we_o  (s_we[0]),
    .s0_wbd_cyc_o (s_cyc[0]),
    .s0_wbd_stb_o (s_stb[0]),
    .s1_wbd_dat_i (s_rdat[1]),
    .s1_wbd_ack_i (s_ack[1]),
    .s1_wbd_dat_o (s_wdat[1]),
    .s1_wbd_adr_o (s_adr[1]),
    .s1_wbd_sel_o (s_sel[1]),
    .s1_wbd_we_o  (s_we[1]),
    .s1_wbd_cyc_o (s_cyc[1]),
    .s1_wbd_stb_o (s_stb[1]),
    .s2_wbd_dat_i (s_rdat[2]),
    .s2_wbd_ack_i (s_ack[2]),
    .s2_wbd_dat_o (s_wdat[2]),
    .s2_wbd_adr_o (s2_adr),
    .s2_wbd_sel_o (s_sel[2]),
    .s2_wbd_we_o  (s_we[2]),
    .s2_wbd_cyc_o (s_cyc[2]),
    .s2_wbd_stb_o (s_stb[2]),
    .s3_wbd_dat_i (s_rdat[3]),
    .s3_wbd_ack_i (s_ack[3]),
    .s3_wbd_dat_o (s_wdat[3]),
    .s3_wbd_adr_o (s3_adr),
    .s3_wbd_sel_o (s_sel[3]),
    .s3_wbd_we_o  (s_we[3]),
    .s3_wbd_cyc_o (s_cyc[3]),
    .s3_wbd_stb_o (s_stb[3])
  );

  // ----------------------------
  // Helpers
  // ----------------------------

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else stop_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
  endtask

  // 16-bit Galois LFSR
  // Output bit is bit 0 before the step
  function automatic logic [15:0] lfsr_next(input logic [15:0] st);
    logic [15:0] nxt;
    nxt = st >> 1;
    if (st[0]) begin
      nxt = nxt ^ 16'hB400;
    end
    return nxt;
  endfunction

  // Read data of a location never written
  // Slave index sits in bits 15..12 above the low 12 address bits
  function automatic logic [31:0] unwritten_rdata(input int slv, input logic [31:0] adr);
    return (32'(slv) << 12) + {20'd0, adr[11:0]};
  endfunction

  // ----------------------------
  // Slave models
  // ----------------------------

  always @(posedge clk) begin : slave_models
    logic [1:0]  delay;
    logic [1:0]  left;
    logic [33:0] key;
    for (int s = 0; s < 4; s++) begin
      key = {2'(s), s_adr[s]};
      if (!rst_n) begin
        s_ack[s]    <= 1'b0;
        s_rdat[s]   <= '0;
        busy[s]     <= 1'b0;
        wait_cnt[s] <= '0;
      end else if (s_ack[s]) begin
        // Stage drops stb on this edge
        s_ack[s]  <= 1'b0;
        s_rdat[s] <= '0;
        busy[s]   <= 1'b0;
      end else if (busy[s] || s_stb[s]) begin
        if (busy[s]) begin
          // Back-pressure keeps the request in place
          assert (s_stb[s] && s_cyc[s] && s_adr[s] == snap_adr[s] &&
                  s_wdat[s] == snap_wdat[s] && s_sel[s] == snap_sel[s] &&
                  s_we[s] == snap_we[s])
            else stop_run($sformatf("slave %0d request changed before its ack", s));
          left = wait_cnt[s];
        end else begin
          // Two LFSR bits pick the wait of a new strobe
          delay[0] = lfsr[0];
          lfsr     = lfsr_next(lfsr);
          delay[1] = lfsr[0];
          lfsr     = lfsr_next(lfsr);
          left     = delay;
          snap_adr[s]  <= s_adr[s];
          snap_wdat[s] <= s_wdat[s];
          snap_sel[s]  <= s_sel[s];
          snap_we[s]   <= s_we[s];
          last_slv     <= 2'(s);
          last_adr     <= s_adr[s];
          last_wdat    <= s_wdat[s];
          last_sel     <= s_sel[s];
          last_we      <= s_we[s];
          last_cyc     <= s_cyc[s];
        end
        if (left == 2'd0) begin
          if (s_we[s]) begin
            slv_mem[key] = s_wdat[s];
          end
          s_rdat[s] <= slv_mem.exists(key) ? slv_mem[key] : unwritten_rdata(s, s_adr[s]);
          s_ack[s]  <= 1'b1;
          busy[s]   <= 1'b0;
        end else begin
          busy[s]     <= 1'b1;
          wait_cnt[s] <= left - 2'd1;
        end
      end
    end
  end

  // ----------------------------
  // Bus monitor and watchdog
  // ----------------------------

  always @(negedge clk) begin : bus_monitor
    if (!rst_n) begin
      for (int m = 0; m < 3; m++) begin
        served[m] = '0;
      end
    end else begin
      assert ($countones({s_stb[0], s_stb[1], s_stb[2], s_stb[3]}) <= 1)
        else stop_run("more than one slave strobed at the same time");
      assert ($countones({m_ack[0], m_ack[1], m_ack[2]}) <= 1)
        else stop_run("more than one master acknowledged at the same time");
      for (int m = 0; m < 3; m++) begin
        assert (!m_ack[m] || m_stb[m])
          else stop_run($sformatf("master %0d acknowledged with no request open", m));
        if (m_ack[m] || !m_stb[m]) begin
          served[m] = '0;
        end else begin
          // Nobody else finishes twice while m waits
          for (int o = 0; o < 3; o++) begin
            if (o != m && m_ack[o]) begin
              assert (!served[m][o])
                else stop_run($sformatf("master %0d granted twice while master %0d waited",
                                        o, m));
              served[m][o] = 1'b1;
            end
          end
        end
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      stop_run($sformatf("timeout after %0d cycles, transfers never finished", cycle_cnt));
    end
  end

  // ----------------------------
  // Master stimulus
  // ----------------------------

  task automatic do_transfer(input int m, input int idx);
    logic        we;
    logic [31:0] adr;
    logic [31:0] wdat;
    logic [1:0]  exp_slv;
    logic [31:0] exp_adr;
    logic [31:0] exp_dat;
    logic [3:0]  sel;
    logic [33:0] key;
    string       tag;
    we      = txn_mem[idx*TXN_WORDS + 1][0];
    adr     = txn_mem[idx*TXN_WORDS + 2];
    wdat    = txn_mem[idx*TXN_WORDS + 3];
    exp_slv = txn_mem[idx*TXN_WORDS + 4][1:0];
    exp_adr = txn_mem[idx*TXN_WORDS + 5];
    sel     = ~4'(idx);
    key     = {exp_slv, exp_adr};
    tag     = $sformatf("txn%0d m%0d", idx, m);
    @(posedge clk);
    m_adr[m] <= adr;
    m_dat[m] <= wdat;
    m_sel[m] <= sel;
    m_we[m]  <= we;
    m_cyc[m] <= 1'b1;
    m_stb[m] <= 1'b1;
    // Watchdog bounds this wait
    @(negedge clk);
    while (!m_ack[m]) begin
      @(negedge clk);
    end
    check_value({tag, " slave"}, 32'(exp_slv), 32'(last_slv));
    check_value({tag, " address"}, exp_adr, last_adr);
    check_value({tag, " wdata"}, wdat, last_wdat);
    check_value({tag, " sel"}, 32'(sel), 32'(last_sel));
    check_value({tag, " we"}, 32'(we), 32'(last_we));
    check_value({tag, " cyc"}, 32'd1, 32'(last_cyc));
    if (we) begin
      exp_mem[key] = wdat;
    end else begin
      exp_dat = exp_mem.exists(key) ? exp_mem[key] : unwritten_rdata(int'(exp_slv), exp_adr);
      check_value({tag, " rdata"}, exp_dat, m_rdat[m]);
    end
    @(posedge clk);
    m_cyc[m] <= 1'b0;
    m_stb[m] <= 1'b0;
    m_we[m]  <= 1'b0;
  endtask

  // Each master walks its own lines in file order
  task automatic run_master(input int m);
    for (int i = 0; i < NUM_TXN; i++) begin
      if (txn_mem[i*TXN_WORDS] == 32'(m)) begin
        do_transfer(m, i);
      end
    end
  endtask

  initial begin : main_seq
    for (int m = 0; m < 3; m++) begin
      m_dat[m] = '0;
      m_adr[m] = '0;
      m_sel[m] = '0;
      m_we[m]  = 1'b0;
      m_cyc[m] = 1'b0;
      m_stb[m] = 1'b0;
    end
    $readmemh("wb_interconnect_input.txt", txn_mem);
    wait (rst_n === 1'b1);
    @(negedge clk);
    // Idle bus right after reset
    for (int s = 0; s < 4; s++) begin
      check_value($sformatf("reset s%0d stb", s), 32'd0, 32'(s_stb[s]));
    end
    for (int m = 0; m < 3; m++) begin
      check_value($sformatf("reset m%0d ack", m), 32'd0, 32'(m_ack[m]));
    end
    // All three masters contend from the start
    fork
      run_master(0);
      run_master(1);
      run_master(2);
    join
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* wb_interconnect.f */
wbi_bus_pkg.sv
wbi_map_pkg.sv
wbi_req_if.sv
wbi_rr_arbiter.sv
wbi_target_decode.sv
wbi_stage_xbar.sv
wb_interconnect.sv
tb_clock_gen.sv
tb_wb_interconnect.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_wb_interconnect -f wb_interconnect.f -o tb_sim > sim.log 2>&1 &&
  ./obj_dir/tb_sim >> sim.log 2>&1
grep -q "^PASS: all tests$" sim.log && echo "simulation passed" ||
  { echo "simulation failed, see sim.log"; exit 1; }

/* wb_interconnect_input.txt */
// master write_flag address write_data expected_slave expected_trimmed_address
// All fields hex, one transaction per line
0 1 30000010 a5a50001 2 00000010
0 0 30000010 00000000 2 00000010
0 0 00000123 00000000 0 00000120
0 0 2123456a 00000000 1 01234568
0 1 30010044 12345678 3 00000044
1 0 10000200 00000000 0 10000200
1 0 30000084 00000000 2 00000084
1 1 20000400 cafef00d 1 00000400
1 0 20000400 00000000 1 00000400
1 0 7fff0003 00000000 0 7fff0000
2 1 30010008 0000005a 3 00000008
2 0 30010008 00000000 3 00000008
2 0 30020010 00000000 0 30020010
2 1 00000ffc 11223344 0 00000ffc
2 0 00000ffd 00000000 0 00000ffc
